/* Makefile */
SIM      := verilator
SIMFLAGS := --binary --timing --timescale 1ns/1ps
TOP      := dyn_mem_tb
FILELIST := dyn_mem.f
OBJDIR   := obj_dir
PASS_MSG := Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# The run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* include/dyn_mem_tb_tasks.svh */
`ifndef DYN_MEM_TB_TASKS_SVH
`define DYN_MEM_TB_TASKS_SVH

////////////////////
// Compare
////////////////////

task automatic check_data(string name, data_t got, data_t exp);
    if (timed_out) return;
    check_count++;
    if (got !== exp) begin
        $display("ERROR %s: got %h, expected %h", name, got, exp);
        error_count++;
    end
endtask

task automatic check_flag(string name, logic got, logic exp);
    if (timed_out) return;
    check_count++;
    if (got !== exp) begin
        $display("ERROR %s: got %h, expected %h", name, got, exp);
        error_count++;
    end
endtask

////////////////////
// Drive and wait
////////////////////

task automatic set_limit(addr_t limit_v);
    @(posedge clk);
    interleave_limit <= limit_v;
    // Model lookups see the new boundary from here on
    @(negedge clk);
endtask

task automatic drive_request(int unsigned p, logic we_v, addr_t addr_v, data_t wdata_v,
                             strb_t strb_v);
    @(posedge clk);
    req[p]   <= 1'b1;
    we[p]    <= we_v;
    addr[p]  <= addr_v;
    wdata[p] <= wdata_v;
    strb[p]  <= strb_v;
endtask

task automatic wait_grant(int unsigned p);
    int unsigned cycles;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!gnt[p] && cycles < TIMEOUT);
    if (!gnt[p]) begin
        $display("Port %0d was not granted within %0d cycles", p, TIMEOUT);
        error_count++;
        timed_out = 1'b1;
    end
endtask

task automatic wait_rvalid(int unsigned p, output int unsigned cycles);
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!rvalid[p] && cycles < TIMEOUT);
    if (!rvalid[p]) begin
        $display("Port %0d got no rvalid_o within %0d cycles", p, TIMEOUT);
        error_count++;
        timed_out = 1'b1;
    end
endtask

// Hold the request until granted and collect the response
task automatic access(int unsigned p, logic we_v, addr_t addr_v, data_t wdata_v,
                      strb_t strb_v, output data_t rdata_v);
    int unsigned lat;
    rdata_v = '0;
    if (timed_out) return;
    drive_request(p, we_v, addr_v, wdata_v, strb_v);
    wait_grant(p);
    if (timed_out) return;
    @(posedge clk);
    req[p] <= 1'b0;
    wait_rvalid(p, lat);
    if (!timed_out && lat != 1) begin
        $display("Port %0d saw rvalid_o %0d cycles after acceptance, not 1", p, lat);
        error_count++;
    end
    rdata_v = rdata[p];
    // Response is a single-cycle pulse
    @(negedge clk);
    check_flag("rvalid_o", rvalid[p], 1'b0);
endtask

task automatic write_word(int unsigned p, addr_t addr_v, data_t wdata_v, strb_t strb_v);
    data_t unused_rdata;
    int unsigned idx;
    idx = model_index(addr_v, interleave_limit);
    access(p, 1'b1, addr_v, wdata_v, strb_v, unused_rdata);
    model_mem[idx] = merge_bytes(model_mem[idx], wdata_v, strb_v);
endtask

task automatic read_check(int unsigned p, addr_t addr_v, data_t exp);
    data_t got;
    access(p, 1'b0, addr_v, '0, '0, got);
    check_data("rdata_o", got, exp);
endtask

`endif

/* dv/dyn_mem_tb.sv */
module dyn_mem_tb import dyn_mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned NUM_PORT    = 2;
    localparam int unsigned MODEL_WORDS = NUM_BANK_GROUP * (2 ** ROW_BITS);
    localparam int unsigned TIMEOUT     = 50;
    localparam int unsigned NUM_RANDOM  = 200;

    logic                 clk;
    logic                 reset;
    addr_t                interleave_limit;
    logic  [NUM_PORT-1:0] req;
    logic  [NUM_PORT-1:0] we;
    addr_t [NUM_PORT-1:0] addr;
    data_t [NUM_PORT-1:0] wdata;
    strb_t [NUM_PORT-1:0] strb;
    logic  [NUM_PORT-1:0] gnt;
    logic  [NUM_PORT-1:0] rvalid;
    data_t [NUM_PORT-1:0] rdata;

    // Reference memory indexed by group * 128 + row
    data_t       model_mem [MODEL_WORDS];
    logic [31:0] lfsr_q;
    int unsigned error_count;
    int unsigned check_count;
    int unsigned test_count;
    int unsigned failed_tests;
    logic        timed_out;

    dyn_mem_top #(
        .NUM_PORT (NUM_PORT)
    ) dut (
        .clk_i              (clk             ),
        .reset_i            (reset           ),
        .interleave_limit_i (interleave_limit),
        .req_i              (req             ),
        .we_i               (we              ),
        .addr_i             (addr            ),
        .wdata_i            (wdata           ),
        .strb_i             (strb            ),
        .gnt_o              (gnt             ),
        .rvalid_o           (rvalid          ),
        .rdata_o            (rdata           )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    ////////////////////
    // Stimulus helpers
    ////////////////////

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic lfsr_step();
        logic fb;
        fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(int unsigned n);
        logic [63:0] v;
        v = '0;
        for (int unsigned i = 0; i < n; i++) begin
            v = {v[62:0], lfsr_step()};
        end
        return v;
    endfunction

    // Word index is byte address bits 11:3
    function automatic int unsigned model_index(addr_t a, addr_t limit);
        logic [8:0] widx;
        widx = a[11:3];
        if (a < limit) begin
            return 32'(widx[1:0]) * 128 + 32'(widx[8:2]);
        end
        return 32'(widx[8:7]) * 128 + 32'(widx[6:0]);
    endfunction

    function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t s);
        data_t res;
        res = old_word;
        for (int b = 0; b < 8; b++) begin
            if (s[b]) begin
                res[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic data_t model_value(addr_t a);
        return model_mem[model_index(a, interleave_limit)];
    endfunction

    `include "dyn_mem_tb_tasks.svh"

    task automatic finish_test(string name, int unsigned errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            failed_tests++;
            $display("%s: FAILED with %0d errors", name, error_count - errors_before);
        end
    endtask

    ////////////////////
    // Tests
    ////////////////////

    task automatic test_reset_idle();
        int unsigned start;
        start = error_count;
        repeat (10) begin
            @(negedge clk);
            check_flag("gnt_o", |gnt, 1'b0);
            check_flag("rvalid_o", |rvalid, 1'b0);
        end
        finish_test("reset idle", start);
    endtask

    // Every location gets a word that depends on its whole address
    task automatic fill_memory();
        addr_t a;
        set_limit('0);
        for (int unsigned i = 0; i < MODEL_WORDS; i++) begin
            a = i * 8;
            write_word(i % NUM_PORT, a, {a ^ 32'hc3a5_0f96, ~a}, 8'hff);
        end
    endtask

    task automatic test_contiguous();
        int unsigned start;
        start = error_count;
        set_limit('0);
        write_word(0, 32'h0000_0568, 64'h0123_4567_89ab_cdef, 8'hff);
        read_check(0, 32'h0000_0568, 64'h0123_4567_89ab_cdef);
        // Bits above the memory size alias
        read_check(1, 32'h0000_1568, 64'h0123_4567_89ab_cdef);
        finish_test("contiguous write and read", start);
    endtask

    task automatic test_interleave_alias();
        int unsigned start;
        logic [8:0]  i_word;
        addr_t       ilv_addr;
        addr_t       cont_addr;
        start     = error_count;
        i_word    = 9'h05b;
        ilv_addr  = {20'h0, i_word, 3'b000};
        // Interleaved group and row rebuilt as a contiguous word index
        cont_addr = {20'h0, i_word[1:0], i_word[8:2], 3'b000};
        set_limit(32'd2048);
        write_word(0, ilv_addr, 64'hfeed_5a5a_0bad_c0de, 8'hff);
        read_check(1, cont_addr, 64'hfeed_5a5a_0bad_c0de);
        finish_test("interleaved alias", start);
    endtask

    task automatic test_strobes();
        int unsigned start;
        start = error_count;
        write_word(1, 32'h0000_0e40, 64'h1111_2222_3333_4444, 8'hff);
        write_word(0, 32'h0000_0e40, 64'haaaa_bbbb_cccc_dddd, 8'ha5);
        read_check(1, 32'h0000_0e40, 64'haa11_bb22_33cc_44dd);
        finish_test("byte strobes", start);
    endtask

    task automatic test_contention();
        int unsigned start;
        start = error_count;
        set_limit('0);
        // Both in group 0 so only one grant per cycle
        fork
            read_check(0, 32'h0000_0010, model_value(32'h0000_0010));
            read_check(1, 32'h0000_03f8, model_value(32'h0000_03f8));
            begin
                @(posedge clk);
                @(negedge clk);
                check_flag("gnt_o[0]^gnt_o[1]", gnt[0] ^ gnt[1], 1'b1);
            end
        join
        // Groups 0 and 1 proceed together
        fork
            read_check(0, 32'h0000_0010, model_value(32'h0000_0010));
            read_check(1, 32'h0000_0408, model_value(32'h0000_0408));
            begin
                @(posedge clk);
                @(negedge clk);
                check_flag("gnt_o[0]", gnt[0], 1'b1);
                check_flag("gnt_o[1]", gnt[1], 1'b1);
            end
        join
        finish_test("contention", start);
    endtask

    task automatic test_random();
        int unsigned start;
        int unsigned p;
        logic        we_v;
        addr_t       a;
        data_t       d;
        strb_t       s;
        start = error_count;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (n % 50 == 0) begin
                set_limit(addr_t'(rand_bits(12)));
            end
            p    = 32'(rand_bits(1));
            we_v = 1'(rand_bits(1));
            a    = addr_t'(rand_bits(13));
            d    = data_t'(rand_bits(64));
            s    = strb_t'(rand_bits(8));
            if (we_v) begin
                write_word(p, a, d, s);
            end else begin
                read_check(p, a, model_value(a));
            end
        end
        finish_test("random traffic", start);
    endtask

    ////////////////////
    // Sequence
    ////////////////////

    initial begin
        reset            = 1'b1;
        interleave_limit = '0;
        req              = '0;
        we               = '0;
        addr             = '0;
        wdata            = '0;
        strb             = '0;
        lfsr_q           = 32'h65a8;
        error_count      = 0;
        check_count      = 0;
        test_count       = 0;
        failed_tests     = 0;
        timed_out        = 1'b0;

        repeat (8) @(posedge clk);
        reset <= 1'b0;

        if (!timed_out) test_reset_idle();
        if (!timed_out) fill_memory();
        if (!timed_out) test_contiguous();
        if (!timed_out) test_interleave_alias();
        if (!timed_out) test_strobes();
        if (!timed_out) test_contention();
        if (!timed_out) test_random();

        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : dyn_mem_tb

/* dyn_mem.f */
+incdir+include
src/dyn_mem_pkg.sv
src/dyn_mem_addr_map.sv
src/dyn_mem_crossbar.sv
src/dyn_mem_bank_group.sv
src/dyn_mem_top.sv
dv/dyn_mem_tb.sv

/* src/dyn_mem_addr_map.sv */
module dyn_mem_addr_map import dyn_mem_pkg::*; (
    input  addr_t      addr_i,
    input  addr_t      interleave_limit_i,
    output group_idx_t group_o,
    output row_idx_t   row_o
);

    ////////////////////
    // Word index
    ////////////////////

    localparam int unsigned WORD_IDX_BITS = $bits(word_idx_u);

    word_idx_u word_idx;
    logic      below_limit;

    // Drop the byte offset, and anything above the memory size aliases
    assign word_idx = word_idx_u'(addr_i[WORD_OFFSET_BITS +: WORD_IDX_BITS]);

    // Full address against the boundary
    assign below_limit = (addr_i < interleave_limit_i);

    ////////////////////
    // View select
    ////////////////////

    always_comb begin
        if (below_limit) begin
            group_o = word_idx.ilv.group;
            row_o   = word_idx.ilv.row;
        end else begin
            group_o = word_idx.cont.group;
            row_o   = word_idx.cont.row;
        end
    end

endmodule : dyn_mem_addr_map

/* src/dyn_mem_bank_group.sv */
module dyn_mem_bank_group import dyn_mem_pkg::*; (
    input  logic     clk_i,
    input  logic     req_i,
    input  logic     we_i,
    input  row_idx_t row_i,
    input  data_t    wdata_i,
    input  strb_t    strb_i,
    output data_t    rdata_o
);

    localparam int unsigned BANK_STRB_WIDTH = BANK_DATA_WIDTH / 8;
    localparam int unsigned BANK_DEPTH      = 2 ** ROW_BITS;

    ////////////////////
    // Banks
    ////////////////////

    // Bank k covers bytes 4k to 4k+3 of the port word
    for (genvar k = 0; k < BANKS_PER_GROUP; k++) begin : gen_bank

        logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];
        logic [BANK_DATA_WIDTH-1:0] bank_wdata;
        logic [BANK_STRB_WIDTH-1:0] bank_strb;
        logic [BANK_DATA_WIDTH-1:0] rdata_q;

        assign bank_wdata = wdata_i[k*BANK_DATA_WIDTH +: BANK_DATA_WIDTH];
        assign bank_strb  = strb_i[k*BANK_STRB_WIDTH +: BANK_STRB_WIDTH];

        // Byte-wise write
        always_ff @(posedge clk_i) begin
            if (req_i && we_i) begin
                for (int b = 0; b < BANK_STRB_WIDTH; b++) begin
                    if (bank_strb[b]) begin
                        mem[row_i][b*8 +: 8] <= bank_wdata[b*8 +: 8];
                    end
                end
            end
        end

        // Old word comes out, also on a write
        always_ff @(posedge clk_i) begin
            if (req_i) begin
                rdata_q <= mem[row_i];
            end
        end

        assign rdata_o[k*BANK_DATA_WIDTH +: BANK_DATA_WIDTH] = rdata_q;

    end

endmodule : dyn_mem_bank_group

/* src/dyn_mem_crossbar.sv */
module dyn_mem_crossbar import dyn_mem_pkg::*; #(
    parameter int unsigned NUM_PORT = 2
) (
    input  logic                                  clk_i,
    input  logic                                  reset_i,

    // Port requests, already mapped
    input  logic       [NUM_PORT-1:0]             req_i,
    input  logic       [NUM_PORT-1:0]             we_i,
    input  group_idx_t [NUM_PORT-1:0]             group_i,
    input  row_idx_t   [NUM_PORT-1:0]             row_i,
    input  data_t      [NUM_PORT-1:0]             wdata_i,
    input  strb_t      [NUM_PORT-1:0]             strb_i,

    // Port responses
    output logic       [NUM_PORT-1:0]             gnt_o,
    output logic       [NUM_PORT-1:0]             rvalid_o,
    output data_t      [NUM_PORT-1:0]             rdata_o,

    // Bank group side
    output logic       [NUM_BANK_GROUP-1:0]       bank_req_o,
    output logic       [NUM_BANK_GROUP-1:0]       bank_we_o,
    output row_idx_t   [NUM_BANK_GROUP-1:0]       bank_row_o,
    output data_t      [NUM_BANK_GROUP-1:0]       bank_wdata_o,
    output strb_t      [NUM_BANK_GROUP-1:0]       bank_strb_o,
    input  data_t      [NUM_BANK_GROUP-1:0]       bank_rdata_i
);

    localparam int unsigned PTR_BITS = (NUM_PORT > 1) ? $clog2(NUM_PORT) : 1;

    logic [NUM_BANK_GROUP-1:0][PTR_BITS-1:0] rr_q;
    logic [NUM_BANK_GROUP-1:0][PTR_BITS-1:0] win_idx;
    logic [NUM_BANK_GROUP-1:0][NUM_PORT-1:0] grant;

    logic       [NUM_PORT-1:0] gnt_q;
    group_idx_t [NUM_PORT-1:0] group_q;

    ////////////////////
    // Arbitration
    ////////////////////

    // Search starts at the pointer and wraps around the ports
    always_comb begin : arbitrate
        int unsigned cand;

        grant   = '0;
        win_idx = '0;
        for (int g = 0; g < NUM_BANK_GROUP; g++) begin
            for (int i = 0; i < NUM_PORT; i++) begin
                cand = int'(rr_q[g]) + i;
                if (cand >= NUM_PORT) begin
                    cand = cand - NUM_PORT;
                end
                if ((grant[g] == '0) && req_i[cand] &&
                    (group_i[cand] == group_idx_t'(g))) begin
                    grant[g][cand] = 1'b1;
                    win_idx[g]     = cand[PTR_BITS-1:0];
                end
            end
        end
    end

    always_comb begin
        gnt_o = '0;
        for (int g = 0; g < NUM_BANK_GROUP; g++) begin
            gnt_o = gnt_o | grant[g];
        end
    end

    // Pointer moves one past the winner
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_q <= '0;
        end else begin
            for (int g = 0; g < NUM_BANK_GROUP; g++) begin
                if (bank_req_o[g]) begin
                    if (win_idx[g] == PTR_BITS'(NUM_PORT - 1)) begin
                        rr_q[g] <= '0;
                    end else begin
                        rr_q[g] <= win_idx[g] + 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////
    // Bank group drive
    ////////////////////

    always_comb begin
        for (int g = 0; g < NUM_BANK_GROUP; g++) begin
            bank_req_o[g]   = |grant[g];
            bank_we_o[g]    = we_i[win_idx[g]];
            bank_row_o[g]   = row_i[win_idx[g]];
            bank_wdata_o[g] = wdata_i[win_idx[g]];
            bank_strb_o[g]  = strb_i[win_idx[g]];
        end
    end

    ////////////////////
    // Response routing
    ////////////////////

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            gnt_q <= '0;
        end else begin
            gnt_q <= gnt_o;
        end
    end

    // Group of the granted request, used one cycle later
    always_ff @(posedge clk_i) begin
        for (int p = 0; p < NUM_PORT; p++) begin
            if (gnt_o[p]) begin
                group_q[p] <= group_i[p];
            end
        end
    end

    assign rvalid_o = gnt_q;

    always_comb begin
        for (int p = 0; p < NUM_PORT; p++) begin
            rdata_o[p] = bank_rdata_i[group_q[p]];
        end
    end

endmodule : dyn_mem_crossbar

/* src/dyn_mem_pkg.sv */
package dyn_mem_pkg;

    ////////////////////
    // Geometry
    ////////////////////

    localparam int unsigned ADDR_WIDTH       = 32;
    localparam int unsigned DATA_WIDTH       = 64;
    localparam int unsigned BANK_DATA_WIDTH  = 32;
    localparam int unsigned NUM_BANK_GROUP   = 4;
    localparam int unsigned BANKS_PER_GROUP  = DATA_WIDTH / BANK_DATA_WIDTH;
    localparam int unsigned MEM_SIZE_BYTES   = 4096;

    // Derived index widths
    localparam int unsigned WORD_OFFSET_BITS = $clog2(DATA_WIDTH / 8);
    localparam int unsigned GROUP_BITS       = $clog2(NUM_BANK_GROUP);
    localparam int unsigned ROW_BITS         =
        $clog2(MEM_SIZE_BYTES / (DATA_WIDTH / 8) / NUM_BANK_GROUP);

    ////////////////////
    // Types
    ////////////////////

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [DATA_WIDTH/8-1:0] strb_t;

    typedef logic [GROUP_BITS-1:0]   group_idx_t;
    typedef logic [ROW_BITS-1:0]     row_idx_t;

    // Word index seen two ways
    // Interleaved: consecutive words step through the groups first
    // Contiguous: each group owns one block of rows
    typedef union packed {
        struct packed {
            row_idx_t   row;
            group_idx_t group;
        } ilv;
        struct packed {
            group_idx_t group;
            row_idx_t   row;
        } cont;
    } word_idx_u;

endpackage : dyn_mem_pkg

/* src/dyn_mem_top.sv */
module dyn_mem_top import dyn_mem_pkg::*; #(
    parameter int unsigned NUM_PORT = 2
) (
    input  logic                  clk_i,
    input  logic                  reset_i,

    // Boundary between interleaved and contiguous mapping
    input  addr_t                 interleave_limit_i,

    // Request ports
    input  logic  [NUM_PORT-1:0]  req_i,
    input  logic  [NUM_PORT-1:0]  we_i,
    input  addr_t [NUM_PORT-1:0]  addr_i,
    input  data_t [NUM_PORT-1:0]  wdata_i,
    input  strb_t [NUM_PORT-1:0]  strb_i,
    output logic  [NUM_PORT-1:0]  gnt_o,
    output logic  [NUM_PORT-1:0]  rvalid_o,
    output data_t [NUM_PORT-1:0]  rdata_o
);

    ////////////////////
    // Signals
    ////////////////////

    group_idx_t [NUM_PORT-1:0]       port_group;
    row_idx_t   [NUM_PORT-1:0]       port_row;

    logic       [NUM_BANK_GROUP-1:0] bank_req;
    logic       [NUM_BANK_GROUP-1:0] bank_we;
    row_idx_t   [NUM_BANK_GROUP-1:0] bank_row;
    data_t      [NUM_BANK_GROUP-1:0] bank_wdata;
    strb_t      [NUM_BANK_GROUP-1:0] bank_strb;
    data_t      [NUM_BANK_GROUP-1:0] bank_rdata;

    ////////////////////
    // Address mapping
    ////////////////////

    for (genvar p = 0; p < NUM_PORT; p++) begin : gen_addr_map
        dyn_mem_addr_map i_dyn_mem_addr_map (
            .addr_i             (addr_i[p]         ),
            .interleave_limit_i (interleave_limit_i),
            .group_o            (port_group[p]     ),
            .row_o              (port_row[p]       )
        );
    end

    ////////////////////
    // Crossbar
    ////////////////////

    dyn_mem_crossbar #(
        .NUM_PORT (NUM_PORT)
    ) i_dyn_mem_crossbar (
        .clk_i        (clk_i     ),
        .reset_i      (reset_i   ),
        .req_i        (req_i     ),
        .we_i         (we_i      ),
        .group_i      (port_group),
        .row_i        (port_row  ),
        .wdata_i      (wdata_i   ),
        .strb_i       (strb_i    ),
        .gnt_o        (gnt_o     ),
        .rvalid_o     (rvalid_o  ),
        .rdata_o      (rdata_o   ),
        .bank_req_o   (bank_req  ),
        .bank_we_o    (bank_we   ),
        .bank_row_o   (bank_row  ),
        .bank_wdata_o (bank_wdata),
        .bank_strb_o  (bank_strb ),
        .bank_rdata_i (bank_rdata)
    );

    ////////////////////
    // Bank groups
    ////////////////////

    for (genvar g = 0; g < NUM_BANK_GROUP; g++) begin : gen_bank_group
        dyn_mem_bank_group i_dyn_mem_bank_group (
            .clk_i   (clk_i        ),
            .req_i   (bank_req[g]  ),
            .we_i    (bank_we[g]   ),
            .row_i   (bank_row[g]  ),
            .wdata_i (bank_wdata[g]),
            .strb_i  (bank_strb[g] ),
            .rdata_o (bank_rdata[g])
        );
    end

endmodule : dyn_mem_top
